// ==== source/noc_macros.svh ====
// Sizing constants shared by the router VC control RTL and its testbench
// Include wherever port, VC or credit counts are needed
// Guarded so several files can include it in one compile unit

`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// Router ports, port 0 is the local port
`define NUM_PORTS 5

// Virtual channels per port
`define NUM_VCS 4

// Downstream flit buffers per VC, also the credit count after reset
`define BUFFER_DEPTH 8

// Default round-trip threshold loaded into every port at reset
`define ROUND_TRIP 2

// Credit counter width, wide enough to hold BUFFER_DEPTH itself
`define CR_BITS ($clog2(`BUFFER_DEPTH) + 1)

`endif

// ==== source/noc_pkg.sv ====
// Vector types for the router VC control logic
// Modules import it inside the body, ports use scoped names

`default_nettype none

`include "noc_macros.svh"

package noc_pkg;

    // Router port number, 0 is local and 1 to 4 are mesh links
    typedef logic [$clog2(`NUM_PORTS)-1:0] port_idx_t;

    // VC number within one port
    typedef logic [$clog2(`NUM_VCS)-1:0] vc_idx_t;

    // Credit count, also used for the per-port threshold
    typedef logic [`CR_BITS-1:0] credit_t;

    // One bit per output VC of every port
    // Bit index is port * NUM_VCS + vc
    typedef logic [`NUM_PORTS*`NUM_VCS-1:0] vc_mask_t;

    // One bit per VC of the link ports only
    // Bit index is (port - 1) * NUM_VCS + vc, the local port has no credits
    typedef logic [(`NUM_PORTS-1)*`NUM_VCS-1:0] link_vc_mask_t;

endpackage

`default_nettype wire

// ==== source/vc_threshold_regs.sv ====
// Per-output-port round-trip thresholds for the VC credit check
// Written one port at a time through the cfg_write strobe
// Every entry comes out of reset at the default round-trip value

`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module vc_threshold_regs (
    input  wire logic             clk,
    input  wire logic             reset,
    // Configuration write, one port per strobe
    input  wire logic             cfg_write,
    input  wire noc_pkg::port_idx_t cfg_port,
    input  wire noc_pkg::credit_t   cfg_threshold,
    // Current threshold of every output port
    output noc_pkg::credit_t        port_thresholds [`NUM_PORTS-1:0]
);
    import noc_pkg::*;

    // One write enable per port
    logic [`NUM_PORTS-1:0] wr_en;

    // Decode the target port, out-of-range numbers match no entry
    always_comb begin
        wr_en = '0;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (cfg_write && (cfg_port == port_idx_t'(p))) begin
                wr_en[p] = 1'b1;
            end
        end
    end

    // Threshold storage
    // Port 0 keeps a value too, the local port simply never reads it
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                port_thresholds[p] <= credit_t'(`ROUND_TRIP);
            end
        end else begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                if (wr_en[p]) begin
                    port_thresholds[p] <= cfg_threshold;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/vc_availability.sv ====
// Credit tracking for the output VCs of the link ports
// Counts grants against downstream credit returns and flags the VCs
// still above their port's threshold; also pulses credits upstream

`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module vc_availability (
    input  wire logic                  clk,
    input  wire logic                  reset,
    // Thresholds from the configuration registers
    input  wire noc_pkg::credit_t      port_thresholds [`NUM_PORTS-1:0],
    // One pulse per credit handed back by a downstream router
    input  wire noc_pkg::link_vc_mask_t dwnstr_credit_increment,
    // Allocation event from the allocator, same cycle as the request
    input  wire logic                  alloc_fire,
    input  wire noc_pkg::port_idx_t    alloc_in_port,
    input  wire noc_pkg::vc_idx_t      alloc_in_vc,
    input  wire noc_pkg::port_idx_t    alloc_dst_port,
    input  wire noc_pkg::vc_idx_t      alloc_op_vc,
    // Available output VCs, port 0 bits are always set
    output noc_pkg::vc_mask_t          vc_availability,
    // One-cycle credit pulse to the upstream router
    output noc_pkg::link_vc_mask_t     upstr_credit_increment
);
    import noc_pkg::*;

    localparam int LINK_VCS = (`NUM_PORTS - 1) * `NUM_VCS;

    // Credit counters, flat index (port - 1) * NUM_VCS + vc
    credit_t       credits [LINK_VCS-1:0];

    // Output VC that loses a credit this cycle
    link_vc_mask_t take_mask;

    // Input VC whose buffer slot frees up this cycle
    link_vc_mask_t free_mask;

    // Decode the allocation event into one-hot masks
    // Local port on either side has no credit bookkeeping
    always_comb begin
        take_mask = '0;
        free_mask = '0;
        for (int p = 1; p < `NUM_PORTS; p++) begin
            for (int v = 0; v < `NUM_VCS; v++) begin
                if (alloc_fire && (alloc_dst_port == port_idx_t'(p)) &&
                    (alloc_op_vc == vc_idx_t'(v))) begin
                    take_mask[(p-1)*`NUM_VCS+v] = 1'b1;
                end
                if (alloc_fire && (alloc_in_port == port_idx_t'(p)) &&
                    (alloc_in_vc == vc_idx_t'(v))) begin
                    free_mask[(p-1)*`NUM_VCS+v] = 1'b1;
                end
            end
        end
    end

    // Credit counters
    // Grant and return on one VC in the same cycle leave it unchanged
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < LINK_VCS; i++) begin
                credits[i] <= credit_t'(`BUFFER_DEPTH);
            end
        end else begin
            for (int i = 0; i < LINK_VCS; i++) begin
                case ({take_mask[i], dwnstr_credit_increment[i]})
                    // A fire only reaches a VC above threshold, so no underflow
                    2'b10: credits[i] <= credits[i] - credit_t'(1);
                    2'b01: begin
                        // Saturate at the buffer depth
                        if (credits[i] < credit_t'(`BUFFER_DEPTH)) begin
                            credits[i] <= credits[i] + credit_t'(1);
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Availability, strictly above threshold so a count cannot skip the test
    always_comb begin
        vc_availability = '0;
        for (int v = 0; v < `NUM_VCS; v++) begin
            vc_availability[v] = 1'b1;
        end
        for (int p = 1; p < `NUM_PORTS; p++) begin
            for (int v = 0; v < `NUM_VCS; v++) begin
                vc_availability[p*`NUM_VCS+v] =
                    (credits[(p-1)*`NUM_VCS+v] > port_thresholds[p]);
            end
        end
    end

    // Upstream pulse lines up with the grant
    always_ff @(posedge clk) begin
        if (reset) begin
            upstr_credit_increment <= '0;
        end else begin
            upstr_credit_increment <= free_mask;
        end
    end

endmodule

`default_nettype wire

// ==== source/vc_allocator.sv ====
// Output VC allocation, one request per cycle
// Picks the lowest-numbered available VC on the destination port and
// answers with a registered grant or nack in the following cycle

`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module vc_allocator (
    input  wire logic               clk,
    input  wire logic               reset,
    // Allocation request
    input  wire logic               req,
    input  wire noc_pkg::port_idx_t req_port,
    input  wire noc_pkg::vc_idx_t   req_vc,
    input  wire noc_pkg::port_idx_t req_dst_port,
    // Current availability of every output VC
    input  wire noc_pkg::vc_mask_t  vc_availability,
    // Combinational allocation event for the credit tracker
    output logic                    alloc_fire,
    output noc_pkg::port_idx_t      alloc_in_port,
    output noc_pkg::vc_idx_t        alloc_in_vc,
    output noc_pkg::port_idx_t      alloc_dst_port,
    output noc_pkg::vc_idx_t        alloc_op_vc,
    // Registered response, one cycle after the request
    output logic                    grant,
    output noc_pkg::vc_idx_t        grant_op_vc,
    output logic                    nack
);
    import noc_pkg::*;

    // Availability slice of the destination port
    logic [`NUM_VCS-1:0] dst_avail;

    // Priority search result
    logic    found;
    vc_idx_t pick;

    // Select the destination slice, an unknown port sees nothing free
    always_comb begin
        dst_avail = '0;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (req_dst_port == port_idx_t'(p)) begin
                dst_avail = vc_availability[p*`NUM_VCS +: `NUM_VCS];
            end
        end
    end

    // Scan from the top down so the lowest free VC is the last one kept
    always_comb begin
        found = 1'b0;
        pick  = '0;
        for (int v = `NUM_VCS - 1; v >= 0; v--) begin
            if (dst_avail[v]) begin
                found = 1'b1;
                pick  = vc_idx_t'(v);
            end
        end
    end

    // Allocation event to the credit tracker
    assign alloc_fire     = req && found;
    assign alloc_in_port  = req_port;
    assign alloc_in_vc    = req_vc;
    assign alloc_dst_port = req_dst_port;
    assign alloc_op_vc    = pick;

    // Response strobes, a request with no free VC is dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            grant <= 1'b0;
            nack  <= 1'b0;
        end else begin
            grant <= alloc_fire;
            nack  <= req && !found;
        end
    end

    // Granted VC, only meaningful while grant is high
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            grant_op_vc <= pick;
        end
    end

endmodule

`default_nettype wire

// ==== source/router_vc_ctrl.sv ====
// Top of the router output-VC control
// Ties the threshold registers, the credit tracker and the allocator
// together; the testbench drives requests and credit returns here

`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module router_vc_ctrl (
    input  wire logic                   clk,
    input  wire logic                   reset,
    // Threshold configuration
    input  wire logic                   cfg_write,
    input  wire noc_pkg::port_idx_t     cfg_port,
    input  wire noc_pkg::credit_t       cfg_threshold,
    // VC allocation request
    input  wire logic                   req,
    input  wire noc_pkg::port_idx_t     req_port,
    input  wire noc_pkg::vc_idx_t       req_vc,
    input  wire noc_pkg::port_idx_t     req_dst_port,
    // Credits returned by the neighbours
    input  wire noc_pkg::link_vc_mask_t dwnstr_credit_increment,
    // Status and responses
    output noc_pkg::vc_mask_t           vc_availability,
    output logic                        grant,
    output noc_pkg::vc_idx_t            grant_op_vc,
    output logic                        nack,
    output noc_pkg::link_vc_mask_t      upstr_credit_increment
);
    import noc_pkg::*;

    // Thresholds per output port
    credit_t   port_thresholds [`NUM_PORTS-1:0];

    // Allocation event from allocator to tracker
    logic      alloc_fire;
    port_idx_t alloc_in_port;
    vc_idx_t   alloc_in_vc;
    port_idx_t alloc_dst_port;
    vc_idx_t   alloc_op_vc;

    vc_threshold_regs u_thresholds (
        .clk             (clk),
        .reset           (reset),
        .cfg_write       (cfg_write),
        .cfg_port        (cfg_port),
        .cfg_threshold   (cfg_threshold),
        .port_thresholds (port_thresholds)
    );

    vc_availability u_credits (
        .clk                     (clk),
        .reset                   (reset),
        .port_thresholds         (port_thresholds),
        .dwnstr_credit_increment (dwnstr_credit_increment),
        .alloc_fire              (alloc_fire),
        .alloc_in_port           (alloc_in_port),
        .alloc_in_vc             (alloc_in_vc),
        .alloc_dst_port          (alloc_dst_port),
        .alloc_op_vc             (alloc_op_vc),
        .vc_availability         (vc_availability),
        .upstr_credit_increment  (upstr_credit_increment)
    );

    vc_allocator u_allocator (
        .clk             (clk),
        .reset           (reset),
        .req             (req),
        .req_port        (req_port),
        .req_vc          (req_vc),
        .req_dst_port    (req_dst_port),
        .vc_availability (vc_availability),
        .alloc_fire      (alloc_fire),
        .alloc_in_port   (alloc_in_port),
        .alloc_in_vc     (alloc_in_vc),
        .alloc_dst_port  (alloc_dst_port),
        .alloc_op_vc     (alloc_op_vc),
        .grant           (grant),
        .grant_op_vc     (grant_op_vc),
        .nack            (nack)
    );

endmodule

`default_nettype wire

// ==== tests/router_vc_ctrl_asserts.sv ====
// Concurrent checks on the router VC control top, attached by bind
// Response exclusivity, local-port availability and request ordering

`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module router_vc_ctrl_asserts (
    input wire logic              clk,
    input wire logic              reset,
    input wire logic              req,
    input wire logic              grant,
    input wire logic              nack,
    input wire noc_pkg::vc_mask_t vc_availability
);
    import noc_pkg::*;

    // A request is answered one way only
    grant_nack_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(grant && nack)
    ) else $error("grant and nack high in the same cycle");

    // Local port has no credit limit
    local_always_available: assert property (
        @(posedge clk) disable iff (reset) (&vc_availability[`NUM_VCS-1:0])
    ) else $error("local port VC reported as unavailable");

    // Responses come exactly one cycle after a request
    response_follows_request: assert property (
        @(posedge clk) disable iff (reset) (grant || nack) |-> $past(req)
    ) else $error("grant or nack without a request in the previous cycle");

endmodule

bind router_vc_ctrl router_vc_ctrl_asserts u_asserts (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .grant           (grant),
    .nack            (nack),
    .vc_availability (vc_availability)
);

`default_nettype wire

// ==== tests/router_vc_ctrl_tb.sv ====
// Random-stimulus testbench for the router VC control top
// A cycle model of the credits and thresholds predicts grant, nack,
// the chosen VC, the upstream pulses and the availability mask
// Compiled through verilog.f and run by run_sim.sh

`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module router_vc_ctrl_tb;
    import noc_pkg::*;

    localparam int LINK_VCS   = (`NUM_PORTS - 1) * `NUM_VCS;
    localparam int RESET_CYC  = 4;
    localparam int LEN_RESET  = 4;
    localparam int LEN_ALLOC  = 30;
    localparam int LEN_DRAIN  = 48;
    localparam int LEN_RETURN = 60;
    localparam int LEN_THRESH = 60;
    localparam int LEN_UPSTR  = 54;
    // Every test cycle plus reset, the final flush and some slack
    localparam int MAX_CYCLES = RESET_CYC + LEN_RESET + LEN_ALLOC + LEN_DRAIN +
                                LEN_RETURN + LEN_THRESH + LEN_UPSTR + 1 + 20;

    logic          clk;
    logic          reset;
    logic          cfg_write;
    port_idx_t     cfg_port;
    credit_t       cfg_threshold;
    logic          req;
    port_idx_t     req_port;
    vc_idx_t       req_vc;
    port_idx_t     req_dst_port;
    link_vc_mask_t dwnstr_credit_increment;
    vc_mask_t      vc_availability;
    logic          grant;
    vc_idx_t       grant_op_vc;
    logic          nack;
    link_vc_mask_t upstr_credit_increment;

    // Reference model state as of the last edge
    int            m_credit [LINK_VCS];
    int            m_thr [`NUM_PORTS];
    logic          exp_grant;
    logic          exp_nack;
    vc_idx_t       exp_vc;
    link_vc_mask_t exp_upstr;

    integer        seed;
    int            errors = 0;
    int            checks = 0;
    int            cycles = 0;
    int            nacks_seen = 0;
    int            link_grants = 0;

    router_vc_ctrl u_dut (
        .clk                     (clk),
        .reset                   (reset),
        .cfg_write               (cfg_write),
        .cfg_port                (cfg_port),
        .cfg_threshold           (cfg_threshold),
        .req                     (req),
        .req_port                (req_port),
        .req_vc                  (req_vc),
        .req_dst_port            (req_dst_port),
        .dwnstr_credit_increment (dwnstr_credit_increment),
        .vc_availability         (vc_availability),
        .grant                   (grant),
        .grant_op_vc             (grant_op_vc),
        .nack                    (nack),
        .upstr_credit_increment  (upstr_credit_increment)
    );

    always #10 clk = ~clk;

    // Watchdog on the total run length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_vc(input string what, input vc_idx_t got, input vc_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_mask(input string what, input vc_mask_t got, input vc_mask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_link(input string what, input link_vc_mask_t got,
                              input link_vc_mask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Local bits always set, link VCs strictly above their threshold
    function automatic vc_mask_t model_avail();
        vc_mask_t m;
        m = '0;
        for (int v = 0; v < `NUM_VCS; v++) begin
            m[v] = 1'b1;
        end
        for (int p = 1; p < `NUM_PORTS; p++) begin
            for (int v = 0; v < `NUM_VCS; v++) begin
                m[p*`NUM_VCS+v] = (m_credit[(p-1)*`NUM_VCS+v] > m_thr[p]);
            end
        end
        return m;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < LINK_VCS; i++) begin
            m_credit[i] = `BUFFER_DEPTH;
        end
        for (int p = 0; p < `NUM_PORTS; p++) begin
            m_thr[p] = `ROUND_TRIP;
        end
        exp_grant = 1'b0;
        exp_nack  = 1'b0;
        exp_vc    = '0;
        exp_upstr = '0;
    endtask

    // Drive at the rising edge and check at the falling edge
    // Then predict what the next rising edge does with these inputs
    task automatic drive_cycle(input logic r, input port_idx_t rp, input vc_idx_t rv,
                               input port_idx_t rd, input link_vc_mask_t ret,
                               input logic cw, input port_idx_t cp, input credit_t ct);
        vc_mask_t avail;
        logic     found;
        int       pick;
        int       take_idx;
        @(posedge clk);
        req                     <= r;
        req_port                <= rp;
        req_vc                  <= rv;
        req_dst_port            <= rd;
        dwnstr_credit_increment <= ret;
        cfg_write               <= cw;
        cfg_port                <= cp;
        cfg_threshold           <= ct;
        @(negedge clk);
        check_bit("grant", grant, exp_grant);
        check_bit("nack", nack, exp_nack);
        if (exp_grant) begin
            check_vc("grant_op_vc", grant_op_vc, exp_vc);
        end
        check_link("upstr_credit_increment", upstr_credit_increment, exp_upstr);
        avail = model_avail();
        check_mask("vc_availability", vc_availability, avail);
        // Lowest free VC on the destination port
        found = 1'b0;
        pick  = 0;
        for (int v = 0; v < `NUM_VCS; v++) begin
            if (r && !found && avail[int'(rd)*`NUM_VCS+v]) begin
                found = 1'b1;
                pick  = v;
            end
        end
        exp_grant = r && found;
        exp_nack  = r && !found;
        exp_upstr = '0;
        if (exp_grant) begin
            exp_vc = vc_idx_t'(pick);
        end
        if (exp_nack) begin
            nacks_seen++;
        end
        if (exp_grant && rp != 0) begin
            exp_upstr[(int'(rp)-1)*`NUM_VCS+int'(rv)] = 1'b1;
            link_grants++;
        end
        take_idx = -1;
        if (exp_grant && rd != 0) begin
            take_idx = (int'(rd) - 1) * `NUM_VCS + pick;
        end
        // Grant and return on one VC cancel out
        for (int i = 0; i < LINK_VCS; i++) begin
            if (i == take_idx && !ret[i]) begin
                m_credit[i]--;
            end else if (i != take_idx && ret[i] && m_credit[i] < `BUFFER_DEPTH) begin
                m_credit[i]++;
            end
        end
        if (cw && int'(cp) < `NUM_PORTS) begin
            m_thr[cp] = int'(ct);
        end
    endtask

    // Random request to a random destination
    // Credit returns and threshold writes only when enabled
    task automatic random_cycle(input logic ret_on, input logic cfg_on);
        logic          r;
        port_idx_t     rp;
        vc_idx_t       rv;
        port_idx_t     rd;
        link_vc_mask_t ret;
        logic          cw;
        port_idx_t     cp;
        credit_t       ct;
        r   = (rand_below(4) != 0);
        rp  = port_idx_t'(rand_below(`NUM_PORTS));
        rv  = vc_idx_t'(rand_below(`NUM_VCS));
        rd  = port_idx_t'(rand_below(`NUM_PORTS));
        ret = '0;
        if (ret_on) begin
            ret = link_vc_mask_t'($random(seed) & $random(seed));
        end
        cw  = cfg_on && (rand_below(2) == 0);
        // Out-of-range ports 5 to 7 must be ignored
        cp  = port_idx_t'(rand_below(8));
        ct  = credit_t'(rand_below(10));
        drive_cycle(r, rp, rv, rd, ret, cw, cp, ct);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%s finished, %0d mismatches", name, errors - errs_before);
    endtask

    initial begin
        int start;
        int marker;
        seed                    = 54784;
        clk                     = 1'b0;
        reset                   = 1'b1;
        cfg_write               = 1'b0;
        cfg_port                = '0;
        cfg_threshold           = '0;
        req                     = 1'b0;
        req_port                = '0;
        req_vc                  = '0;
        req_dst_port            = '0;
        dwnstr_credit_increment = '0;
        model_reset();
        repeat (RESET_CYC) @(posedge clk);
        reset <= 1'b0;

        // Idle after reset
        start = errors;
        repeat (LEN_RESET) drive_cycle(0, 0, 0, 0, '0, 0, 0, 0);
        report_test("reset", start);

        // Requests only, credits just drain
        start = errors;
        repeat (LEN_ALLOC) random_cycle(1'b0, 1'b0);
        report_test("allocation", start);

        // Three of four requests to port 3, the rest to the local port
        start  = errors;
        marker = nacks_seen;
        for (int k = 0; k < LEN_DRAIN; k++) begin
            drive_cycle(1'b1, port_idx_t'(k % `NUM_PORTS), vc_idx_t'(rand_below(`NUM_VCS)),
                        (k % 4 == 3) ? port_idx_t'(0) : port_idx_t'(3), '0, 0, 0, 0);
        end
        if (nacks_seen == marker) begin
            errors++;
            $display("Exhaustion test never drained port 3 down to its threshold");
        end
        report_test("exhaustion", start);

        start = errors;
        repeat (LEN_RETURN) random_cycle(1'b1, 1'b0);
        report_test("returns", start);

        start = errors;
        repeat (LEN_THRESH) random_cycle(1'b1, 1'b1);
        report_test("thresholds", start);

        // Restore the default thresholds so grants keep coming
        start  = errors;
        marker = link_grants;
        for (int p = 1; p < `NUM_PORTS; p++) begin
            drive_cycle(0, 0, 0, 0, '0, 1'b1, port_idx_t'(p), credit_t'(`ROUND_TRIP));
        end
        repeat (LEN_UPSTR - 4) random_cycle(1'b1, 1'b0);
        if (link_grants == marker) begin
            errors++;
            $display("Upstream test saw no grant from a link input port");
        end
        report_test("upstream", start);

        // Flush so the last prediction is checked too
        drive_cycle(0, 0, 0, 0, '0, 0, 0, 0);
        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+source
source/noc_pkg.sv
source/vc_threshold_regs.sv
source/vc_availability.sv
source/vc_allocator.sv
source/router_vc_ctrl.sv
tests/router_vc_ctrl_asserts.sv
tests/router_vc_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the router VC control testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module router_vc_ctrl_tb -o sim_router_vc_ctrl

./obj_dir/sim_router_vc_ctrl 2>&1 | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED, see sim.log"
    exit 1
fi
